// File: hw/core_ctrl_pkg.sv
//////////////////////////////
// core control package
// constants, settings record, PLL config
// word and the video output word
//////////////////////////////

`default_nettype none

package core_ctrl_pkg;

  localparam int BRIDGE_W = 32;

  // settings register offsets
  localparam logic [BRIDGE_W-1:0] ADDR_IOCTL_DOWNLOAD = 32'h0000_0000;
  localparam logic [BRIDGE_W-1:0] ADDR_ROM_SIZE       = 32'h0000_0004;
  localparam logic [BRIDGE_W-1:0] ADDR_ROM_TYPE       = 32'h0000_0008;
  localparam logic [BRIDGE_W-1:0] ADDR_RAM_SIZE       = 32'h0000_000C;
  localparam logic [BRIDGE_W-1:0] ADDR_PAL            = 32'h0000_0010;
  localparam logic [BRIDGE_W-1:0] ADDR_RESET          = 32'h0000_0050;
  localparam logic [BRIDGE_W-1:0] ADDR_MULTITAP       = 32'h0000_0100;
  localparam logic [BRIDGE_W-1:0] ADDR_LIGHTGUN       = 32'h0000_0104;
  localparam logic [BRIDGE_W-1:0] ADDR_AIM_SPEED      = 32'h0000_0108;
  localparam logic [BRIDGE_W-1:0] ADDR_VIDEO_4_3      = 32'h0000_0200;

  // read regions, matched on the top address bits
  localparam logic [7:0] RD_REGION_CMD  = 8'hF8;
  localparam logic [3:0] RD_REGION_SAVE = 4'h2;

  localparam int RESET_HOLD_CYCLES = 256;
  localparam int RESET_CNT_W       = $clog2(RESET_HOLD_CYCLES + 1);
  localparam logic [RESET_CNT_W-1:0] RESET_HOLD_LOAD = RESET_CNT_W'(RESET_HOLD_CYCLES);

  // reconfiguration sequencer steps
  localparam int PLL_STEP_W = 8;
  localparam logic [PLL_STEP_W-1:0] PLL_STEP_MODE        = 8'd1;
  localparam logic [PLL_STEP_W-1:0] PLL_STEP_MIF         = 8'd3;
  localparam logic [PLL_STEP_W-1:0] PLL_STEP_START       = 8'd5;
  localparam logic [PLL_STEP_W-1:0] PLL_STEP_WAIT        = 8'd7;
  localparam logic [PLL_STEP_W-1:0] PLL_STEP_RESET_START = 8'd8;
  localparam logic [PLL_STEP_W-1:0] PLL_STEP_RESET_END   = 8'd28;

  localparam logic [5:0] CFG_ADDR_MODE  = 6'd0;
  localparam logic [5:0] CFG_ADDR_MIF   = 6'd31;
  localparam logic [5:0] CFG_ADDR_START = 6'd2;

  // weekday is not tracked by the host
  localparam logic [7:0] RTC_WEEKDAY = 8'd1;

  typedef struct packed {
    logic       ioctl_download;
    logic [3:0] rom_size;
    logic [7:0] rom_type;
    logic [3:0] ram_size;
    logic       pal;
    logic       multitap_enabled;
    logic       lightgun_enabled;
    logic       lightgun_type;
    logic [7:0] aim_speed;
    logic       use_4_3_video;
    logic [1:0] spare;
  } core_settings_t;

  typedef struct packed {
    logic       toggle;
    logic [7:0] empty;
    logic [7:0] weekday;
    logic [7:0] year;
    logic [7:0] month;
    logic [7:0] day;
    logic [7:0] hour;
    logic [7:0] minute;
    logic [7:0] second;
  } rtc_word_t;

  typedef struct packed {
    logic                write;
    logic [5:0]          address;
    logic [BRIDGE_W-1:0] data;
  } pll_cfg_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } video_pixel_t;

  // slot descriptor sent to the scaler in blanking
  typedef struct packed {
    logic [8:0]  zero_hi;
    logic        field_odd;
    logic        aspect_4_3;
    logic [12:0] zero_lo;
  } video_slot_t;

  typedef union packed {
    video_pixel_t pixel;
    video_slot_t  slot;
  } video_word_u;

endpackage

`default_nettype wire

// File: hw/bridge_regs.sv
//////////////////////////////
// bridge register bank
// settings writes and read data routing
//////////////////////////////

`default_nettype none

module bridge_regs (
  input  wire                                clk_74a,
  input  wire                                pll_core_locked,
  input  wire [core_ctrl_pkg::BRIDGE_W-1:0]  bridge_addr,
  input  wire                                bridge_wr,
  input  wire [core_ctrl_pkg::BRIDGE_W-1:0]  bridge_wr_data,
  input  wire [core_ctrl_pkg::BRIDGE_W-1:0]  cmd_rd_data,
  input  wire [core_ctrl_pkg::BRIDGE_W-1:0]  save_rd_data,
  output logic [core_ctrl_pkg::BRIDGE_W-1:0] bridge_rd_data,
  output core_ctrl_pkg::core_settings_t      settings,
  output logic                               reset_cmd
);

  //////////////////////////////
  // read routing

  // command space first, then save data, zero elsewhere
  always_comb begin
    if (bridge_addr[core_ctrl_pkg::BRIDGE_W-1 -: 8] == core_ctrl_pkg::RD_REGION_CMD) begin
      bridge_rd_data = cmd_rd_data;
    end else if (bridge_addr[core_ctrl_pkg::BRIDGE_W-1 -: 4] == core_ctrl_pkg::RD_REGION_SAVE) begin
      bridge_rd_data = save_rd_data;
    end else begin
      bridge_rd_data = '0;
    end
  end

  //////////////////////////////
  // settings writes

  // one cycle, the write itself is a single-cycle strobe
  assign reset_cmd = bridge_wr && (bridge_addr == core_ctrl_pkg::ADDR_RESET);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        core_ctrl_pkg::ADDR_IOCTL_DOWNLOAD: begin
          settings.ioctl_download <= bridge_wr_data[0];
        end
        core_ctrl_pkg::ADDR_ROM_SIZE: begin
          settings.rom_size <= bridge_wr_data[3:0];
        end
        core_ctrl_pkg::ADDR_ROM_TYPE: begin
          settings.rom_type <= bridge_wr_data[7:0];
        end
        core_ctrl_pkg::ADDR_RAM_SIZE: begin
          settings.ram_size <= bridge_wr_data[3:0];
        end
        core_ctrl_pkg::ADDR_PAL: begin
          settings.pal <= bridge_wr_data[0];
        end
        core_ctrl_pkg::ADDR_MULTITAP: begin
          settings.multitap_enabled <= bridge_wr_data[0];
        end
        // enable and gun type share one word
        core_ctrl_pkg::ADDR_LIGHTGUN: begin
          settings.lightgun_enabled <= bridge_wr_data[0];
          settings.lightgun_type    <= bridge_wr_data[1];
        end
        core_ctrl_pkg::ADDR_AIM_SPEED: begin
          settings.aim_speed <= bridge_wr_data[7:0];
        end
        core_ctrl_pkg::ADDR_VIDEO_4_3: begin
          settings.use_4_3_video <= bridge_wr_data[0];
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/core_reset_gen.sv
//////////////////////////////
// core reset generator
// holds reset after a host command
//////////////////////////////

`default_nettype none

module core_reset_gen (
  input  wire  clk_74a,
  input  wire  pll_core_locked,
  input  wire  reset_cmd,
  output logic core_reset
);

  logic [core_ctrl_pkg::RESET_CNT_W-1:0] hold_cnt;

  // a new command reloads the full hold
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt <= '0;
    end else if (reset_cmd) begin
      hold_cnt <= core_ctrl_pkg::RESET_HOLD_LOAD;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // unlocked clocks also keep the core in reset
  assign core_reset = (hold_cnt != '0) || !pll_core_locked;

endmodule

`default_nettype wire

// File: hw/rtc_packer.sv
//////////////////////////////
// RTC word packer
// console clock word with change toggle
//////////////////////////////

`default_nettype none

module rtc_packer (
  input  wire                       clk_74a,
  input  wire                       pll_core_locked,
  input  wire [31:0]                rtc_date,
  input  wire [31:0]                rtc_time,
  output core_ctrl_pkg::rtc_word_t  rtc
);

  logic [31:0] prev_time;
  logic        toggle;

  // toggle flips once per new time value
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_time <= '0;
      toggle    <= 1'b0;
    end else if (rtc_time != prev_time) begin
      prev_time <= rtc_time;
      toggle    <= ~toggle;
    end
  end

  always_comb begin
    rtc.toggle  = toggle;
    rtc.empty   = 8'h00;
    rtc.weekday = core_ctrl_pkg::RTC_WEEKDAY;
    // year is the low byte only
    rtc.year    = rtc_date[23:16];
    rtc.month   = rtc_date[15:8];
    rtc.day     = rtc_date[7:0];
    rtc.hour    = rtc_time[23:16];
    rtc.minute  = rtc_time[15:8];
    rtc.second  = rtc_time[7:0];
  end

endmodule

`default_nettype wire

// File: hw/pll_reconfig_seq.sv
//////////////////////////////
// PLL reconfiguration sequencer
// reloads the PLL setup on a PAL change
// and resets the PLL afterwards
//////////////////////////////

`default_nettype none

module pll_reconfig_seq (
  input  wire                      clk_74a,
  input  wire                      pll_core_locked,
  input  wire                      pal,
  input  wire                      cfg_waitrequest,
  output core_ctrl_pkg::pll_cfg_t  cfg,
  output logic                     pll_reset,
  output logic                     pal_transitioning
);

  logic                                  pal_d1;
  logic                                  pal_d2;
  logic [core_ctrl_pkg::PLL_STEP_W-1:0]  step;
  logic [core_ctrl_pkg::PLL_STEP_W-1:0]  step_nxt;
  core_ctrl_pkg::pll_cfg_t               cfg_nxt;

  //////////////////////////////
  // step counter

  always_comb begin
    step_nxt = step;
    if (step != '0) begin
      step_nxt = step + 1'b1;
    end
    // stall here until the reconfig block is done
    if ((step == core_ctrl_pkg::PLL_STEP_WAIT) && cfg_waitrequest) begin
      step_nxt = step;
    end
    if (step == core_ctrl_pkg::PLL_STEP_RESET_END) begin
      step_nxt = '0;
    end
    // a PAL change always starts over
    if (pal_d1 != pal_d2) begin
      step_nxt = core_ctrl_pkg::PLL_STEP_MODE;
    end
  end

  //////////////////////////////
  // config writes, data is always zero

  always_comb begin
    cfg_nxt = '0;
    case (step)
      core_ctrl_pkg::PLL_STEP_MODE: begin
        cfg_nxt.write   = 1'b1;
        cfg_nxt.address = core_ctrl_pkg::CFG_ADDR_MODE;
      end
      core_ctrl_pkg::PLL_STEP_MIF: begin
        cfg_nxt.write   = 1'b1;
        cfg_nxt.address = core_ctrl_pkg::CFG_ADDR_MIF;
      end
      core_ctrl_pkg::PLL_STEP_START: begin
        cfg_nxt.write   = 1'b1;
        cfg_nxt.address = core_ctrl_pkg::CFG_ADDR_START;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pal_d1    <= 1'b0;
      pal_d2    <= 1'b0;
      step      <= '0;
      cfg       <= '0;
      pll_reset <= 1'b0;
    end else begin
      pal_d1    <= pal;
      pal_d2    <= pal_d1;
      step      <= step_nxt;
      cfg       <= cfg_nxt;
      // high for every cycle the counter sits in the reset window
      pll_reset <= (step_nxt >= core_ctrl_pkg::PLL_STEP_RESET_START) &&
                   (step_nxt <= core_ctrl_pkg::PLL_STEP_RESET_END);
    end
  end

  assign pal_transitioning = (step != '0) || cfg_waitrequest || cfg.write ||
                             !pll_core_locked;

endmodule

`default_nettype wire

// File: hw/video_slot_inserter.sv
//////////////////////////////
// video slot inserter
// registers pixels, sends the slot word
// in the first blank cycle of each line
//////////////////////////////

`default_nettype none

module video_slot_inserter (
  input  wire                          clk_74a,
  input  wire                          pll_core_locked,
  input  wire                          vid_de,
  input  wire                          vid_vs,
  input  wire [23:0]                   vid_rgb,
  input  wire [7:0]                    snap_index,
  input  wire                          use_4_3_video,
  output logic                         de,
  output core_ctrl_pkg::video_word_u   rgb
);

  logic                        prev_de;
  logic                        prev_vs;
  logic [7:0]                  snap_latched;
  core_ctrl_pkg::video_slot_t  slot_word;

  // field parity comes from the snap point of this frame
  always_comb begin
    slot_word            = '0;
    slot_word.field_odd  = ~snap_latched[0];
    slot_word.aspect_4_3 = use_4_3_video;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_de      <= 1'b0;
      prev_vs      <= 1'b0;
      de           <= 1'b0;
      snap_latched <= '0;
      rgb          <= '0;
    end else begin
      prev_de <= vid_de;
      prev_vs <= vid_vs;
      de      <= vid_de;
      if (vid_vs && !prev_vs) begin
        snap_latched <= snap_index;
      end
      if (vid_de) begin
        rgb.pixel <= vid_rgb;
      end else if (prev_de) begin
        // falling edge of de, slot word goes out
        rgb.slot <= slot_word;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/core_ctrl_top.sv
//////////////////////////////
// core control top level
// bridge settings, core reset, RTC word,
// PLL reconfiguration and video slot path
//////////////////////////////

`default_nettype none

module core_ctrl_top (
  input  wire                                  clk_74a,
  input  wire                                  pll_core_locked,
  // bridge bus, synchronous to clk_74a
  input  wire [core_ctrl_pkg::BRIDGE_W-1:0]    bridge_addr,
  input  wire                                  bridge_wr,
  input  wire [core_ctrl_pkg::BRIDGE_W-1:0]    bridge_wr_data,
  // read strobe belongs to the external command handler
  input  wire                                  bridge_rd,
  output logic [core_ctrl_pkg::BRIDGE_W-1:0]   bridge_rd_data,
  input  wire [core_ctrl_pkg::BRIDGE_W-1:0]    cmd_rd_data,
  input  wire [core_ctrl_pkg::BRIDGE_W-1:0]    save_rd_data,
  output core_ctrl_pkg::core_settings_t        settings,
  output logic                                 core_reset,
  // host clock
  input  wire [31:0]                           rtc_date,
  input  wire [31:0]                           rtc_time,
  output core_ctrl_pkg::rtc_word_t             rtc,
  // PLL reconfiguration port
  input  wire                                  cfg_waitrequest,
  output core_ctrl_pkg::pll_cfg_t              cfg,
  output logic                                 pll_reset,
  output logic                                 pal_transitioning,
  // video from the line generator
  input  wire                                  vid_de,
  input  wire                                  vid_vs,
  input  wire [23:0]                           vid_rgb,
  input  wire [7:0]                            snap_index,
  output logic                                 de,
  output core_ctrl_pkg::video_word_u           rgb
);

  logic reset_cmd;

  bridge_regs bridge_regs0 (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .cmd_rd_data    (cmd_rd_data),
    .save_rd_data   (save_rd_data),
    .bridge_rd_data (bridge_rd_data),
    .settings       (settings),
    .reset_cmd      (reset_cmd)
  );

  core_reset_gen core_reset_gen0 (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .reset_cmd      (reset_cmd),
    .core_reset     (core_reset)
  );

  rtc_packer rtc_packer0 (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .rtc_date       (rtc_date),
    .rtc_time       (rtc_time),
    .rtc            (rtc)
  );

  pll_reconfig_seq pll_reconfig_seq0 (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .pal              (settings.pal),
    .cfg_waitrequest  (cfg_waitrequest),
    .cfg              (cfg),
    .pll_reset        (pll_reset),
    .pal_transitioning(pal_transitioning)
  );

  video_slot_inserter video_slot_inserter0 (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .vid_de         (vid_de),
    .vid_vs         (vid_vs),
    .vid_rgb        (vid_rgb),
    .snap_index     (snap_index),
    .use_4_3_video  (settings.use_4_3_video),
    .de             (de),
    .rgb            (rgb)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
//////////////////////////////
// testbench clock source
// clk_74a and the PLL lock
//////////////////////////////

`default_nettype none

module tb_clock_gen (
  output logic clk_74a,
  output logic pll_core_locked
);

  initial begin
    clk_74a = 1'b0;
    forever #2 clk_74a = ~clk_74a;
  end

  // lock comes up after 16 cycles
  initial begin
    pll_core_locked = 1'b0;
    repeat (16) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/core_ctrl_assertions.sv
//////////////////////////////
// core control checker
// concurrent assertions on the top level
//////////////////////////////

`default_nettype none

module core_ctrl_assertions (
  input wire                                 clk_74a,
  input wire                                 pll_core_locked,
  input wire [31:0]                          bridge_addr,
  input wire                                 bridge_wr,
  input wire [31:0]                          bridge_wr_data,
  input wire [31:0]                          bridge_rd_data,
  input wire [31:0]                          cmd_rd_data,
  input wire [31:0]                          save_rd_data,
  input core_ctrl_pkg::core_settings_t       settings,
  input wire                                 core_reset,
  input wire [31:0]                          rtc_date,
  input wire [31:0]                          rtc_time,
  input core_ctrl_pkg::rtc_word_t            rtc,
  input wire                                 cfg_waitrequest,
  input core_ctrl_pkg::pll_cfg_t             cfg,
  input wire                                 pll_reset,
  input wire                                 pal_transitioning,
  input wire                                 vid_de,
  input wire                                 vid_vs,
  input wire [7:0]                           snap_index,
  input wire [23:0]                          vid_rgb,
  input wire                                 de,
  input core_ctrl_pkg::video_word_u          rgb
);

  int          err_count = 0;
  int          hold_left;
  int          reset_high;
  int          cfg_writes;
  logic        seq_on;
  logic [7:0]  exp_snap;
  logic        vs_q;

  // settings image that one write produces, per register offset
  function automatic logic [31:0] write_image(input logic [31:0] addr, input logic [31:0] d);
    core_ctrl_pkg::core_settings_t s;
    s = '0;
    case (addr)
      32'h000: s.ioctl_download = d[0];
      32'h004: s.rom_size = d[3:0];
      32'h008: s.rom_type = d[7:0];
      32'h00C: s.ram_size = d[3:0];
      32'h010: s.pal = d[0];
      32'h100: s.multitap_enabled = d[0];
      32'h104: begin
        s.lightgun_enabled = d[0];
        s.lightgun_type    = d[1];
      end
      32'h108: s.aim_speed = d[7:0];
      32'h200: s.use_4_3_video = d[0];
      default: s = '0;
    endcase
    return s;
  endfunction

  //////////////////////////////
  // reference models

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_left  <= 0;
      reset_high <= 0;
      cfg_writes <= 0;
      seq_on     <= 1'b0;
      vs_q       <= 1'b0;
      exp_snap   <= '0;
    end else begin
      if (bridge_wr && bridge_addr == 32'h50) begin
        hold_left <= 256;
      end else if (hold_left != 0) begin
        hold_left <= hold_left - 1;
      end
      reset_high <= pll_reset ? reset_high + 1 : 0;
      // sequence runs from the mode write until the PLL reset begins
      if (cfg.write && cfg.address == 6'd0) begin
        seq_on <= 1'b1;
      end else if (pll_reset) begin
        seq_on <= 1'b0;
      end
      if (cfg.write) begin
        cfg_writes <= cfg_writes + 1;
      end else if (pll_reset) begin
        cfg_writes <= 0;
      end
      vs_q       <= vid_vs;
      if (vid_vs && !vs_q) begin
        exp_snap <= snap_index;
      end
    end
  end

  //////////////////////////////
  // bridge

  a_write: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    bridge_wr |=> (settings & write_image($past(bridge_addr), '1)) ==
                  write_image($past(bridge_addr), $past(bridge_wr_data)))
    else begin
      err_count++;
      $error("error settings_write expected %h actual %h",
             write_image($past(bridge_addr), $past(bridge_wr_data)), settings);
    end

  a_keep: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    1'b1 |=> (settings & ~write_image($past(bridge_addr), {32{$past(bridge_wr)}})) ==
             ($past(settings) & ~write_image($past(bridge_addr), {32{$past(bridge_wr)}})))
    else begin
      err_count++;
      $error("error settings_keep expected %h actual %h", $past(settings), settings);
    end

  a_read: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    bridge_rd_data == ((bridge_addr[31:24] == 8'hF8) ? cmd_rd_data :
                       (bridge_addr[31:28] == 4'h2) ? save_rd_data : 32'h0))
    else begin
      err_count++;
      $error("error read_route expected %h actual %h",
             (bridge_addr[31:24] == 8'hF8) ? cmd_rd_data :
             (bridge_addr[31:28] == 4'h2) ? save_rd_data : 32'h0, bridge_rd_data);
    end

  //////////////////////////////
  // reset and RTC

  a_hold: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    core_reset == (hold_left != 0))
    else begin
      err_count++;
      $error("error core_reset_hold expected %0d actual %0d", hold_left != 0, core_reset);
    end

  a_unlocked: assert property (@(posedge clk_74a) !pll_core_locked |-> core_reset)
    else begin
      err_count++;
      $error("core reset was low while the PLL was unlocked");
    end

  a_after_reset: assert property (@(posedge clk_74a) $rose(pll_core_locked) |->
    !cfg.write && !pll_reset && !de && !core_reset && !rtc.toggle)
    else begin
      err_count++;
      $error("an output was not cleared after reset");
    end

  a_toggle: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    ##1 1'b1 |-> (rtc.toggle != $past(rtc.toggle)) == ($past(rtc_time) != $past(rtc_time, 2)))
    else begin
      err_count++;
      $error("error rtc_toggle expected %0d actual %0d",
             $past(rtc.toggle) ^ ($past(rtc_time) != $past(rtc_time, 2)), rtc.toggle);
    end

  a_rtc_fields: assert property (@(posedge clk_74a)
    rtc[63:0] == {8'h00, 8'd1, rtc_date[23:0], rtc_time[23:0]})
    else begin
      err_count++;
      $error("error rtc_fields expected %h actual %h",
             {8'h00, 8'd1, rtc_date[23:0], rtc_time[23:0]}, rtc[63:0]);
    end

  //////////////////////////////
  // PLL reconfiguration

  a_cfg_mif: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    cfg.write && cfg.address == 6'd31 |-> $past(cfg.write, 2) && $past(cfg.address, 2) == 6'd0)
    else begin
      err_count++;
      $error("error cfg_order expected 0 actual %0d", $past(cfg.address, 2));
    end

  a_cfg_start: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    cfg.write && cfg.address == 6'd2 |-> $past(cfg.write, 2) && $past(cfg.address, 2) == 6'd31)
    else begin
      err_count++;
      $error("error cfg_order expected 31 actual %0d", $past(cfg.address, 2));
    end

  a_cfg_pulse: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    cfg.write |-> cfg.data == 32'h0 && (cfg.address inside {6'd0, 6'd31, 6'd2}) ##1 !cfg.write)
    else begin
      err_count++;
      $error("error cfg_pulse expected one zero-data write actual %h", cfg);
    end

  a_cfg_count: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(pll_reset) |-> cfg_writes == 3)
    else begin
      err_count++;
      $error("error cfg_write_count expected 3 actual %0d", cfg_writes);
    end

  a_pll_rise: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(pll_reset) |-> !$past(cfg_waitrequest))
    else begin
      err_count++;
      $error("PLL reset rose while the reconfiguration was still busy");
    end

  a_pll_len: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $fell(pll_reset) |-> reset_high == 21)
    else begin
      err_count++;
      $error("error pll_reset_length expected 21 actual %0d", reset_high);
    end

  a_busy: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    seq_on || cfg.write || pll_reset |-> pal_transitioning)
    else begin
      err_count++;
      $error("pal_transitioning was low during the PLL sequence");
    end

  //////////////////////////////
  // video

  a_pixel: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    vid_de |=> de && rgb == $past(vid_rgb))
    else begin
      err_count++;
      $error("error video_pixel expected %h actual %h", $past(vid_rgb), rgb);
    end

  a_slot: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !vid_de && $past(vid_de) |=>
      !de && rgb == {9'b0, ~$past(exp_snap[0]), $past(settings.use_4_3_video), 13'b0})
    else begin
      err_count++;
      $error("error video_slot expected %h actual %h",
             {9'b0, ~$past(exp_snap[0]), $past(settings.use_4_3_video), 13'b0}, rgb);
    end

endmodule

`default_nettype wire

// File: tests/tb_core_ctrl.sv
//////////////////////////////
// core control testbench
// stimulus, PLL model and run control
//////////////////////////////

`default_nettype none

module tb_core_ctrl;

  localparam int MAX_CYCLES = 4000;

  wire                            clk_74a;
  wire                            pll_core_locked;
  logic [31:0]                    bridge_addr;
  logic                           bridge_wr;
  logic [31:0]                    bridge_wr_data;
  logic                           bridge_rd;
  logic [31:0]                    cmd_rd_data;
  logic [31:0]                    save_rd_data;
  logic [31:0]                    rtc_date;
  logic [31:0]                    rtc_time;
  logic                           cfg_waitrequest;
  logic                           vid_de;
  logic                           vid_vs;
  logic [23:0]                    vid_rgb;
  logic [7:0]                     snap_index;
  logic [31:0]                    bridge_rd_data;
  core_ctrl_pkg::core_settings_t  settings;
  logic                           core_reset;
  core_ctrl_pkg::rtc_word_t       rtc;
  core_ctrl_pkg::pll_cfg_t        cfg;
  logic                           pll_reset;
  logic                           pal_transitioning;
  logic                           de;
  core_ctrl_pkg::video_word_u     rgb;
  logic [31:0]                    rng_state = 32'h6bc2_301c;
  int                             cycles = 0;
  int                             wait_left = 0;

  tb_clock_gen clock0 (.clk_74a(clk_74a), .pll_core_locked(pll_core_locked));

  core_ctrl_top dut0 (.*);

  bind core_ctrl_top core_ctrl_assertions checks0 (.*);

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    @(posedge clk_74a);
    bridge_wr      <= 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr);
    @(posedge clk_74a);
    bridge_addr  <= addr;
    bridge_rd    <= 1'b1;
    cmd_rd_data  <= next_rand();
    save_rd_data <= next_rand();
  endtask

  task automatic video_frame(input int lines);
    @(posedge clk_74a);
    vid_vs     <= 1'b1;
    snap_index <= 8'(next_rand());
    @(posedge clk_74a);
    vid_vs <= 1'b0;
    for (int l = 0; l < lines; l++) begin
      for (int p = 0; p < 8; p++) begin
        @(posedge clk_74a);
        vid_de  <= 1'b1;
        vid_rgb <= 24'(next_rand());
      end
      @(posedge clk_74a);
      vid_de <= 1'b0;
      repeat (3) @(posedge clk_74a);
    end
  endtask

  // PLL model, busy for a few cycles after the start write
  always @(posedge clk_74a) begin
    if (cfg.write && cfg.address == core_ctrl_pkg::CFG_ADDR_START) begin
      cfg_waitrequest <= 1'b1;
      wait_left       <= 1 + int'(next_rand() % 8);
    end else if (wait_left > 1) begin
      wait_left <= wait_left - 1;
    end else begin
      wait_left       <= 0;
      cfg_waitrequest <= 1'b0;
    end
  end

  //////////////////////////////
  // run control

  always @(posedge clk_74a) begin
    cycles <= cycles + 1;
    if (dut0.checks0.err_count != 0) begin
      $display("Simulation failed");
      $fatal(1, "stopped at the first failed check");
    end else if (cycles >= MAX_CYCLES) begin
      $display("Simulation failed");
      $fatal(1, "run did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  initial begin
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    bridge_rd = 1'b0;
    cmd_rd_data = '0;
    save_rd_data = '0;
    rtc_date = '0;
    rtc_time = '0;
    cfg_waitrequest = 1'b0;
    vid_de = 1'b0;
    vid_vs = 1'b0;
    vid_rgb = '0;
    snap_index = '0;
    wait (pll_core_locked);
    repeat (4) @(posedge clk_74a);

    // every settings offset, plus one unmapped address
    bus_write(core_ctrl_pkg::ADDR_IOCTL_DOWNLOAD, next_rand());
    bus_write(core_ctrl_pkg::ADDR_ROM_SIZE, next_rand());
    bus_write(core_ctrl_pkg::ADDR_ROM_TYPE, next_rand());
    bus_write(core_ctrl_pkg::ADDR_RAM_SIZE, next_rand());
    bus_write(core_ctrl_pkg::ADDR_MULTITAP, next_rand());
    bus_write(core_ctrl_pkg::ADDR_LIGHTGUN, next_rand());
    bus_write(core_ctrl_pkg::ADDR_AIM_SPEED, next_rand());
    bus_write(core_ctrl_pkg::ADDR_VIDEO_4_3, next_rand());
    bus_write(32'h0000_003C, next_rand());

    bus_read(32'hF800_0010);
    bus_read(32'h2000_0400);
    bus_read(32'h0000_0010);
    @(posedge clk_74a);
    bridge_rd <= 1'b0;

    // hold starts on the edge after the write, run it to the end
    bus_write(core_ctrl_pkg::ADDR_RESET, next_rand());
    @(posedge clk_74a);
    while (core_reset) @(posedge clk_74a);
    repeat (4) @(posedge clk_74a);

    for (int i = 0; i < 5; i++) begin
      @(posedge clk_74a);
      rtc_time <= next_rand();
      rtc_date <= next_rand();
      repeat (4) @(posedge clk_74a);
    end

    // PAL on, then off again
    for (int i = 0; i < 2; i++) begin
      bus_write(core_ctrl_pkg::ADDR_PAL, (i == 0) ? 32'h1 : 32'h0);
      repeat (3) @(posedge clk_74a);
      while (pal_transitioning) @(posedge clk_74a);
      repeat (4) @(posedge clk_74a);
    end

    bus_write(core_ctrl_pkg::ADDR_VIDEO_4_3, 32'h1);
    video_frame(3);
    bus_write(core_ctrl_pkg::ADDR_VIDEO_4_3, 32'h0);
    video_frame(3);
    repeat (4) @(posedge clk_74a);

    if (dut0.checks0.err_count != 0) begin
      $display("Simulation failed");
      $fatal(1, "a check failed before the end of the run");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
hw/core_ctrl_pkg.sv
hw/bridge_regs.sv
hw/core_reset_gen.sv
hw/rtc_packer.sv
hw/pll_reconfig_seq.sv
hw/video_slot_inserter.sv
hw/core_ctrl_top.sv
tests/tb_clock_gen.sv
tests/core_ctrl_assertions.sv
tests/tb_core_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_ctrl
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || (echo "FAIL: no result line"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
